//--- Bender.yml
package:
  name: cl_hello

sources:
  # Design, package first
  - src/hello_pkg.sv
  - src/ocl_slave_fsm.sv
  - src/hello_reg_bank.sv
  - src/vled_mask.sv
  - src/tick_counter.sv
  - src/cl_hello_top.sv

  # Testbench
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_cl_hello.sv

//--- cl_hello_top.f
+incdir+sim
src/hello_pkg.sv
src/ocl_slave_fsm.sv
src/hello_reg_bank.sv
src/vled_mask.sv
src/tick_counter.sv
src/cl_hello_top.sv
sim/tb_cl_hello.sv

//--- sim/tb_axil_tasks.svh
// AXI-Lite single write and read tasks with handshake timeouts and random back-pressure
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// Cycles the master holds off a response before accepting it
function automatic int unsigned stall_cycles();
  return $urandom_range(6, 0);
endfunction

// One write beat, then a stalled write response
task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
  int unsigned cyc;
  int unsigned stall;
  stall = stall_cycles();
  ocl_req.awvalid <= 1'b1;
  ocl_req.awaddr  <= addr;
  // Data goes out with the address so an early wready would show
  ocl_req.wvalid  <= 1'b1;
  ocl_req.wdata   <= data;
  cyc = 0;
  do begin
    @(posedge clk_main_a0);
    cyc++;
    if (cyc > HS_TIMEOUT) stop_with_failure("Timeout: write address channel never took awvalid");
  end while (!ocl_rsp.awready);
  check_eq("wready", 1'b0, ocl_rsp.wready);
  ocl_req.awvalid <= 1'b0;
  cyc = 0;
  do begin
    @(posedge clk_main_a0);
    cyc++;
    if (cyc > HS_TIMEOUT) stop_with_failure("Timeout: write data channel never raised wready");
  end while (!ocl_rsp.wready);
  ocl_req.wvalid <= 1'b0;
  cyc = 0;
  do begin
    @(posedge clk_main_a0);
    cyc++;
    if (cyc > HS_TIMEOUT) stop_with_failure("Timeout: write response never arrived");
  end while (!ocl_rsp.bvalid);
  check_eq("bresp", RESP_OKAY, ocl_rsp.bresp);
  repeat (stall) begin
    @(posedge clk_main_a0);
    check_eq("bvalid", 1'b1, ocl_rsp.bvalid);
    check_eq("awready", 1'b0, ocl_rsp.awready);
  end
  ocl_req.bready <= 1'b1;
  @(posedge clk_main_a0);
  check_eq("bvalid", 1'b1, ocl_rsp.bvalid);
  ocl_req.bready <= 1'b0;
endtask

// One read, with rdata held for the whole stall
task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
  int unsigned cyc;
  int unsigned stall;
  stall = stall_cycles();
  ocl_req.arvalid <= 1'b1;
  ocl_req.araddr  <= addr;
  cyc = 0;
  do begin
    @(posedge clk_main_a0);
    cyc++;
    if (cyc > HS_TIMEOUT) stop_with_failure("Timeout: read address channel never took arvalid");
  end while (!ocl_rsp.arready);
  ocl_req.arvalid <= 1'b0;
  cyc = 0;
  do begin
    @(posedge clk_main_a0);
    cyc++;
    if (cyc > HS_TIMEOUT) stop_with_failure("Timeout: read data never arrived");
  end while (!ocl_rsp.rvalid);
  data = ocl_rsp.rdata;
  check_eq("rresp", RESP_OKAY, ocl_rsp.rresp);
  repeat (stall) begin
    @(posedge clk_main_a0);
    check_eq("rvalid", 1'b1, ocl_rsp.rvalid);
    check_eq("rdata", data, ocl_rsp.rdata);
    check_eq("arready", 1'b0, ocl_rsp.arready);
  end
  ocl_req.rready <= 1'b1;
  @(posedge clk_main_a0);
  check_eq("rdata", data, ocl_rsp.rdata);
  ocl_req.rready <= 1'b0;
endtask

`endif

//--- sim/tb_cl_hello.sv
// Testbench for the register block with clock, reset, stimulus, reference model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_cl_hello
  import hello_pkg::*;
;

  localparam int unsigned HS_TIMEOUT = 64;
  localparam int unsigned POLL_LIMIT = 60;

  logic             clk_main_a0 = 1'b0;
  logic             rst_main_n_sync;
  axil_req_t        ocl_req;
  axil_rsp_t        ocl_rsp;
  logic [LED_W-1:0] vdip;
  logic [LED_W-1:0] vled;

  // Expected register contents
  logic [DATA_W-1:0] exp_hello;
  logic [DATA_W-1:0] exp_ctrl;
  logic [DATA_W-1:0] exp_load;
  logic [15:0]       exp_wmark;

  always #4 clk_main_a0 = ~clk_main_a0;

  cl_hello_top u_cl_hello_top (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ocl_req         (ocl_req),
    .ocl_rsp         (ocl_rsp),
    .vdip            (vdip),
    .vled            (vled)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] got);
    assert (got === exp) else begin
      stop_with_failure($sformatf("Mismatch at %0t ns: %s expected %h, got %h",
                                  $time, name, exp, got));
    end
  endtask

  `include "tb_axil_tasks.svh"

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic [DATA_W-1:0] byte_swap(input logic [DATA_W-1:0] v);
    logic [DATA_W-1:0] r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = v[8*(3-i) +: 8];
    end
    return r;
  endfunction

  task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    axil_write(addr, data);
    case (addr)
      HELLO_WORLD_ADDR: exp_hello = data;
      // Pulse bits never read back
      CNT_CTRL_ADDR:    exp_ctrl = data & 32'h0000_ff03;
      CNT_LOAD_ADDR:    exp_load = data & 32'h0000_ffff;
      CNT_WMARK_ADDR:   exp_wmark = data[15:0];
      default:          ;
    endcase
  endtask

  task automatic expect_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
    logic [DATA_W-1:0] d;
    axil_read(addr, d);
    check_eq($sformatf("rdata at address %h", addr), exp, d);
  endtask

  task automatic check_settings();
    expect_read(HELLO_WORLD_ADDR, byte_swap(exp_hello));
    expect_read(CNT_CTRL_ADDR, exp_ctrl);
    expect_read(CNT_LOAD_ADDR, exp_load);
    expect_read(CNT_WMARK_ADDR, {16'h0000, exp_wmark});
  endtask

  // Watermark flag must agree with the count returned in the same read
  task automatic read_status(output logic [15:0] count, output logic [7:0] ticks);
    logic [DATA_W-1:0] d;
    axil_read(CNT_STATUS_ADDR, d);
    check_eq("status bits 31:25", '0, d[31:25]);
    check_eq("ge_watermark", d[15:0] >= exp_wmark, d[24]);
    count = d[15:0];
    ticks = d[23:16];
  endtask

  // ------------------------------
  // Channel stall checks
  // ------------------------------
  a_bvalid_stall : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ocl_rsp.bvalid && !ocl_req.bready |=> ocl_rsp.bvalid)
    else stop_with_failure($sformatf("Mismatch at %0t ns: bvalid expected 1, got %b",
                                     $time, ocl_rsp.bvalid));

  a_arready_stall : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ocl_rsp.rvalid && !ocl_req.rready |=> !ocl_rsp.arready)
    else stop_with_failure($sformatf("Mismatch at %0t ns: arready expected 0, got %b",
                                     $time, ocl_rsp.arready));

  initial begin
    logic [DATA_W-1:0] d;
    logic [LED_W-1:0]  dip;
    logic [15:0]       cnt;
    logic [7:0]        ticks;
    int unsigned       polls;
    void'($urandom(32'habc27ebd));
    rst_main_n_sync = 1'b0;
    ocl_req         = '0;
    vdip            = '0;
    exp_hello       = '0;
    exp_ctrl        = '0;
    exp_load        = '0;
    exp_wmark       = '0;
    repeat (3) @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
    @(posedge clk_main_a0);
    check_eq("awready", 1'b1, ocl_rsp.awready);
    check_eq("arready", 1'b1, ocl_rsp.arready);
    check_eq("bvalid", 1'b0, ocl_rsp.bvalid);
    check_eq("rvalid", 1'b0, ocl_rsp.rvalid);
    check_eq("vled", '0, vled);

    // Hello-world and LED shadow
    repeat (4) begin
      write_reg(HELLO_WORLD_ADDR, $urandom());
      expect_read(HELLO_WORLD_ADDR, byte_swap(exp_hello));
      expect_read(VLED_ADDR, {16'h0000, exp_hello[15:0]});
      dip = $urandom();
      vdip <= dip;
      repeat (4) @(posedge clk_main_a0);
      check_eq("vled", exp_hello[15:0] & dip, vled);
    end

    // ------------------------------
    // Counter
    // ------------------------------
    write_reg(CNT_WMARK_ADDR, $urandom());
    write_reg(CNT_LOAD_ADDR, 32'h0000_fff0);
    write_reg(CNT_CTRL_ADDR, 32'h0000_020b);
    polls = 0;
    do begin
      read_status(cnt, ticks);
      polls++;
      if (polls > POLL_LIMIT) stop_with_failure("Counter never reached saturation");
    end while (cnt != 16'hffff);
    repeat (20) @(posedge clk_main_a0);
    read_status(cnt, ticks);
    check_eq("count", 16'hffff, cnt);
    // Clear with enable dropped in the same write
    write_reg(CNT_CTRL_ADDR, 32'h0000_0204);
    read_status(cnt, ticks);
    check_eq("count", '0, cnt);
    check_eq("tick_count", '0, ticks);
    d = $urandom();
    write_reg(CNT_LOAD_ADDR, d);
    write_reg(CNT_CTRL_ADDR, 32'h0000_0008);
    read_status(cnt, ticks);
    check_eq("count", d[15:0], cnt);
    write_reg(CNT_WMARK_ADDR, d[15:0]);
    read_status(cnt, ticks);
    check_eq("count", d[15:0], cnt);
    check_settings();

    // Unmapped and read-only addresses
    expect_read(32'h0000_0018, UNIMPLEMENTED_REG_VALUE);
    expect_read($urandom() | 32'h0000_1000, UNIMPLEMENTED_REG_VALUE);
    write_reg($urandom() | 32'h0000_1000, $urandom());
    write_reg(VLED_ADDR, $urandom());
    write_reg(CNT_STATUS_ADDR, $urandom());
    check_settings();

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/cl_hello_top.sv
// Top level connecting the AXI-Lite slave, register bank, LED path and counter
`timescale 1ns/1ps
`default_nettype none

module cl_hello_top
  import hello_pkg::*;
(
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  axil_req_t        ocl_req,
  output axil_rsp_t        ocl_rsp,
  input  logic [LED_W-1:0] vdip,
  output logic [LED_W-1:0] vled
);

  reg_wr_t           reg_wr;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;
  logic [LED_W-1:0]  hello_low;
  logic [LED_W-1:0]  vled_shadow;
  cnt_ctrl_t         cnt_ctrl;
  cnt_status_t       cnt_status;

  // ------------------------------
  // Bus slave
  // ------------------------------
  ocl_slave_fsm u_ocl_slave_fsm (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .req             (ocl_req),
    .rsp             (ocl_rsp),
    .reg_wr          (reg_wr),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  // Registers and read mux
  hello_reg_bank u_hello_reg_bank (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .vled_shadow     (vled_shadow),
    .hello_low       (hello_low),
    .cnt_ctrl        (cnt_ctrl),
    .cnt_status      (cnt_status)
  );

  // ------------------------------
  // LED path and counter
  // ------------------------------
  vled_mask u_vled_mask (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .hello_low       (hello_low),
    .vdip            (vdip),
    .vled_shadow     (vled_shadow),
    .vled            (vled)
  );

  tick_counter u_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cnt_ctrl        (cnt_ctrl),
    .cnt_status      (cnt_status)
  );

endmodule

`default_nettype wire

//--- src/hello_pkg.sv
// Register map, reset and marker values, bus and control structs, FSM state types
`default_nettype none

package hello_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned LED_W  = 16;

  // ------------------------------
  // Register map
  // ------------------------------
  localparam logic [ADDR_W-1:0] HELLO_WORLD_ADDR = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] VLED_ADDR        = 32'h0000_0004;
  localparam logic [ADDR_W-1:0] CNT_CTRL_ADDR    = 32'h0000_0008;
  localparam logic [ADDR_W-1:0] CNT_LOAD_ADDR    = 32'h0000_000C;
  localparam logic [ADDR_W-1:0] CNT_WMARK_ADDR   = 32'h0000_0010;
  localparam logic [ADDR_W-1:0] CNT_STATUS_ADDR  = 32'h0000_0014;

  // Bit positions inside CNT_CTRL
  localparam int unsigned CTRL_ENABLE_BIT  = 0;
  localparam int unsigned CTRL_ONESHOT_BIT = 1;
  localparam int unsigned CTRL_CLEAR_BIT   = 2;
  localparam int unsigned CTRL_LOAD_BIT    = 3;

  localparam logic [DATA_W-1:0] HELLO_RESET_VALUE       = 32'h0000_0000;
  localparam logic [DATA_W-1:0] UNIMPLEMENTED_REG_VALUE = 32'hdead_c0de;
  localparam logic [1:0]        RESP_OKAY               = 2'b00;

  // ------------------------------
  // Bus and control structs
  // ------------------------------
  typedef struct packed {
    logic              awvalid;
    logic [ADDR_W-1:0] awaddr;
    logic              wvalid;
    logic [DATA_W-1:0] wdata;
    logic              bready;
    logic              arvalid;
    logic [ADDR_W-1:0] araddr;
    logic              rready;
  } axil_req_t;

  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              arready;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
  } axil_rsp_t;

  // One-cycle write strobe into the register bank
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } reg_wr_t;

  typedef struct packed {
    logic        enable;
    logic        oneshot;
    logic        clear;
    logic        load;
    logic [7:0]  tick_value;
    logic [15:0] load_value;
    logic [15:0] watermark;
  } cnt_ctrl_t;

  typedef struct packed {
    logic [15:0] count;
    logic [7:0]  tick_count;
    logic        ge_watermark;
  } cnt_status_t;

  // ------------------------------
  // FSM states
  // ------------------------------
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_LOOKUP,
    RD_RESP
  } rd_state_e;

endpackage

`default_nettype wire

//--- src/hello_reg_bank.sv
// Hello-world and counter-control registers with the register read multiplexer
`timescale 1ns/1ps
`default_nettype none

module hello_reg_bank
  import hello_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  reg_wr_t           reg_wr,
  input  logic [ADDR_W-1:0] rd_addr,
  output logic [DATA_W-1:0] rd_data,
  input  logic [LED_W-1:0]  vled_shadow,
  output logic [LED_W-1:0]  hello_low,
  output cnt_ctrl_t         cnt_ctrl,
  input  cnt_status_t       cnt_status
);

  logic [DATA_W-1:0] hello_q;
  logic [DATA_W-1:0] hello_swapped;
  logic              enable_q;
  logic              oneshot_q;
  logic [7:0]        tick_value_q;
  logic [15:0]       load_value_q;
  logic [15:0]       watermark_q;
  logic              wr_hello;
  logic              wr_ctrl;
  logic              wr_load;
  logic              wr_wmark;

  // ------------------------------
  // Write decode
  // ------------------------------
  // Read-only and unmapped addresses match nothing here
  assign wr_hello = reg_wr.valid && (reg_wr.addr == HELLO_WORLD_ADDR);
  assign wr_ctrl  = reg_wr.valid && (reg_wr.addr == CNT_CTRL_ADDR);
  assign wr_load  = reg_wr.valid && (reg_wr.addr == CNT_LOAD_ADDR);
  assign wr_wmark = reg_wr.valid && (reg_wr.addr == CNT_WMARK_ADDR);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q      <= HELLO_RESET_VALUE;
      enable_q     <= 1'b0;
      oneshot_q    <= 1'b0;
      tick_value_q <= '0;
      load_value_q <= '0;
      watermark_q  <= '0;
    end else begin
      if (wr_hello) begin
        hello_q <= reg_wr.data;
      end
      if (wr_ctrl) begin
        enable_q     <= reg_wr.data[CTRL_ENABLE_BIT];
        oneshot_q    <= reg_wr.data[CTRL_ONESHOT_BIT];
        tick_value_q <= reg_wr.data[15:8];
      end
      if (wr_load) begin
        load_value_q <= reg_wr.data[15:0];
      end
      if (wr_wmark) begin
        watermark_q <= reg_wr.data[15:0];
      end
    end
  end

  assign hello_low = hello_q[LED_W-1:0];

  // Clear and load are taken straight from the strobe, so they last one cycle
  always_comb begin
    cnt_ctrl.enable     = enable_q;
    cnt_ctrl.oneshot    = oneshot_q;
    cnt_ctrl.clear      = wr_ctrl && reg_wr.data[CTRL_CLEAR_BIT];
    cnt_ctrl.load       = wr_ctrl && reg_wr.data[CTRL_LOAD_BIT];
    cnt_ctrl.tick_value = tick_value_q;
    cnt_ctrl.load_value = load_value_q;
    cnt_ctrl.watermark  = watermark_q;
  end

  // ------------------------------
  // Read multiplexer
  // ------------------------------
  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  always_comb begin
    case (rd_addr)
      HELLO_WORLD_ADDR: rd_data = hello_swapped;
      VLED_ADDR:        rd_data = {16'h0000, vled_shadow};
      // Pulse bits 3:2 always read back as zero
      CNT_CTRL_ADDR:    rd_data = {16'h0000, tick_value_q, 6'b00_0000, oneshot_q, enable_q};
      CNT_LOAD_ADDR:    rd_data = {16'h0000, load_value_q};
      CNT_WMARK_ADDR:   rd_data = {16'h0000, watermark_q};
      CNT_STATUS_ADDR:  rd_data = {7'b000_0000, cnt_status.ge_watermark,
                                   cnt_status.tick_count, cnt_status.count};
      default:          rd_data = UNIMPLEMENTED_REG_VALUE;
    endcase
  end

endmodule

`default_nettype wire

//--- src/ocl_slave_fsm.sv
// AXI-Lite slave with write and read FSMs producing register strobes and read lookups
`timescale 1ns/1ps
`default_nettype none

module ocl_slave_fsm
  import hello_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  axil_req_t         req,
  output axil_rsp_t         rsp,
  output reg_wr_t           reg_wr,
  output logic [ADDR_W-1:0] rd_addr,
  input  logic [DATA_W-1:0] rd_data
);

  wr_state_e         wr_state;
  rd_state_e         rd_state;
  logic [ADDR_W-1:0] wr_addr_q;
  logic [ADDR_W-1:0] rd_addr_q;
  logic [DATA_W-1:0] rdata_q;
  logic              aw_hs;
  logic              w_hs;
  logic              ar_hs;

  assign aw_hs = (wr_state == WR_IDLE) && req.awvalid;
  // wready follows wvalid directly once the address is held
  assign w_hs  = (wr_state == WR_DATA) && req.wvalid;
  assign ar_hs = (rd_state == RD_IDLE) && req.arvalid;

  // ------------------------------
  // Write channel
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE: if (aw_hs) wr_state <= WR_DATA;
        WR_DATA: if (w_hs) wr_state <= WR_RESP;
        WR_RESP: if (req.bready) wr_state <= WR_IDLE;
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (aw_hs) begin
      wr_addr_q <= req.awaddr;
    end
  end

  always_comb begin
    reg_wr.valid = w_hs;
    reg_wr.addr  = wr_addr_q;
    reg_wr.data  = req.wdata;
  end

  // ------------------------------
  // Read channel
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE:   if (ar_hs) rd_state <= RD_LOOKUP;
        RD_LOOKUP: rd_state <= RD_RESP;
        RD_RESP:   if (req.rready) rd_state <= RD_IDLE;
        default:   rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (ar_hs) begin
      rd_addr_q <= req.araddr;
    end
    // Bank data is sampled once, then held through back-pressure
    if (rd_state == RD_LOOKUP) begin
      rdata_q <= rd_data;
    end
  end

  assign rd_addr = rd_addr_q;

  always_comb begin
    rsp.awready = (wr_state == WR_IDLE);
    rsp.wready  = w_hs;
    rsp.bvalid  = (wr_state == WR_RESP);
    rsp.bresp   = RESP_OKAY;
    rsp.arready = (rd_state == RD_IDLE);
    rsp.rvalid  = (rd_state == RD_RESP);
    rsp.rdata   = rdata_q;
    rsp.rresp   = RESP_OKAY;
  end

  // ------------------------------
  // Protocol checks
  // ------------------------------
  a_bvalid_hold : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rsp.bvalid && !req.bready |=> rsp.bvalid);

  a_rvalid_hold : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata));

  // Each strobe is the single data beat of a write and is answered next cycle
  a_strobe_once : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    reg_wr.valid |=> rsp.bvalid && !reg_wr.valid);

endmodule

`default_nettype wire

//--- src/tick_counter.sv
// Prescaler tick counter, event counter with saturation and watermark compare
`timescale 1ns/1ps
`default_nettype none

module tick_counter
  import hello_pkg::*;
(
  input  logic        clk_main_a0,
  input  logic        rst_main_n_sync,
  input  cnt_ctrl_t   cnt_ctrl,
  output cnt_status_t cnt_status
);

  logic [7:0]  tick_cnt_q;
  logic [15:0] count_q;
  logic        tick;
  logic        saturated;

  // Restart also covers a tick value lowered below the running count
  assign tick      = (tick_cnt_q >= cnt_ctrl.tick_value);
  assign saturated = cnt_ctrl.oneshot && (count_q == 16'hffff);

  // ------------------------------
  // Prescaler
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_cnt_q <= '0;
    end else if (cnt_ctrl.clear) begin
      tick_cnt_q <= '0;
    end else if (cnt_ctrl.enable) begin
      if (tick) begin
        tick_cnt_q <= '0;
      end else begin
        tick_cnt_q <= tick_cnt_q + 8'd1;
      end
    end
  end

  // ------------------------------
  // Event counter
  // ------------------------------
  // Clear and load also act while the counter is disabled
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      count_q <= '0;
    end else if (cnt_ctrl.clear) begin
      count_q <= '0;
    end else if (cnt_ctrl.load) begin
      count_q <= cnt_ctrl.load_value;
    end else if (cnt_ctrl.enable && tick && !saturated) begin
      count_q <= count_q + 16'd1;
    end
  end

  always_comb begin
    cnt_status.count        = count_q;
    cnt_status.tick_count   = tick_cnt_q;
    cnt_status.ge_watermark = (count_q >= cnt_ctrl.watermark);
  end

  // Oneshot mode must never wrap on its own
  a_no_wrap : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    saturated && !cnt_ctrl.clear && !cnt_ctrl.load |=> count_q != 16'h0000);

endmodule

`default_nettype wire

//--- src/vled_mask.sv
// DIP switch synchronizer, LED shadow register and masked LED output flop
`timescale 1ns/1ps
`default_nettype none

module vled_mask
  import hello_pkg::*;
(
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic [LED_W-1:0] hello_low,
  input  logic [LED_W-1:0] vdip,
  output logic [LED_W-1:0] vled_shadow,
  output logic [LED_W-1:0] vled
);

  logic [LED_W-1:0] vdip_q1;
  logic [LED_W-1:0] vdip_q2;
  logic [LED_W-1:0] shadow_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q1  <= '0;
      vdip_q2  <= '0;
      shadow_q <= '0;
      vled     <= '0;
    end else begin
      // Two-flop synchronizer for the switches
      vdip_q1  <= vdip;
      vdip_q2  <= vdip_q1;
      shadow_q <= hello_low;
      // LEDs only light where the matching switch is on
      vled     <= shadow_q & vdip_q2;
    end
  end

  assign vled_shadow = shadow_q;

endmodule

`default_nettype wire
